//--- build.f
rtl/mdu_pkg.sv
rtl/mdu_operand_prep.sv
rtl/mdu_divider.sv
rtl/mdu_multiplier.sv
rtl/mdu_result_format.sv
rtl/mdu_top.sv
test/mdu_clock_gen.sv
test/mdu_assert.sv
test/tb_mdu.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mdu -f build.f -o tb_mdu_sim

# A failing concurrent assertion stops the simulator with an error status
if ! ./obj_dir/tb_mdu_sim > sim.log 2>&1; then
  echo "Simulator exited with an error status"
fi
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "Run ended without a pass line"
  exit 1
fi
exit 0

//--- test/tb_mdu.sv
// Testbench for the RV32 multiply/divide unit
// Directed table, one start-while-busy case, then 200 seeded random ops vs a model
// Inputs change on the falling edge; result is read once ready is seen
`timescale 1ns/100ps

module tb_mdu;

  typedef struct packed {
    mdu_pkg::mdu_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      exp;
  } vec_t;

  localparam int n_random  = 200;
  localparam int latency   = 35;  // Rising edges from start sample to ready
  localparam int op_cycles = 40;  // Cycle budget per operation

  logic              clk;
  logic              reset_n;
  logic              start;
  mdu_pkg::mdu_req_t req;
  logic [31:0]       result;
  logic              busy;
  logic              ready;

  vec_t             vectors[$];  // Directed stimulus table
  vec_t             cur;
  mdu_pkg::mdu_op_e op_r;
  logic [31:0]      rnd;
  logic [31:0]      a_r;
  logic [31:0]      b_r;
  integer           seed;
  int               i;
  int               test_num;
  int               n_pass;
  int               n_fail;
  int               errors;      // Failed checks in total
  int               cycle_count;
  int               timeout_limit;

  mdu_clock_gen clock_gen_inst (
    .clk     (clk),
    .reset_n (reset_n)
  );

  mdu_top mdu_top_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .req     (req),
    .result  (result),
    .busy    (busy),
    .ready   (ready)
  );

  bind mdu_top mdu_assert mdu_assert_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .busy    (busy),
    .ready   (ready)
  );

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: run exceeded %0d cycles without finishing", timeout_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Reference model, RISC-V rules for zero divisor and overflow
  function automatic logic [31:0] model_result(input mdu_pkg::mdu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] a_s;
    logic signed [63:0] b_s;
    logic signed [63:0] a_u;
    logic signed [63:0] b_u;
    logic signed [63:0] prod;
    logic signed [31:0] quo_s;  // Signed quotient, truncated toward zero
    logic signed [31:0] rem_s;  // Signed remainder, sign of a
    logic               ovf;
    a_s = {{32{a[31]}}, a};
    b_s = {{32{b[31]}}, b};
    a_u = {32'd0, a};
    b_u = {32'd0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    quo_s = '0;
    rem_s = '0;
    if ((b != 0) && !ovf) begin
      quo_s = $signed(a) / $signed(b);
      rem_s = $signed(a) % $signed(b);
    end
    case (op)
      mdu_pkg::MULH:   prod = a_s * b_s;
      mdu_pkg::MULHSU: prod = a_s * b_u;
      default:         prod = a_u * b_u;  // Low half is sign agnostic
    endcase
    case (op)
      mdu_pkg::MUL:    return prod[31:0];
      mdu_pkg::MULH,
      mdu_pkg::MULHSU,
      mdu_pkg::MULHU:  return prod[63:32];
      mdu_pkg::DIV:    return (b == 0) ? 32'hffff_ffff : (ovf ? a : quo_s);
      mdu_pkg::DIVU:   return (b == 0) ? 32'hffff_ffff : a / b;
      mdu_pkg::REM:    return (b == 0) ? a : (ovf ? 32'd0 : rem_s);
      default:         return (b == 0) ? a : a % b;  // REMU
    endcase
  endfunction

  task automatic add_vector(input mdu_pkg::mdu_op_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] exp);
    vec_t v;
    v.op  = op;
    v.a   = a;
    v.b   = b;
    v.exp = exp;
    vectors.push_back(v);
  endtask

  // Expected values worked out by hand from the sign rules
  task automatic fill_table();
    add_vector(mdu_pkg::MUL,    32'd7,          32'hffff_fffd, 32'hffff_ffeb);  // 7 * -3
    add_vector(mdu_pkg::MUL,    32'h0001_0000,  32'h0001_0000, 32'h0000_0000);
    add_vector(mdu_pkg::MULH,   32'hffff_fffe,  32'd3,         32'hffff_ffff);  // -2 * 3
    add_vector(mdu_pkg::MULH,   32'h8000_0000,  32'h8000_0000, 32'h4000_0000);
    add_vector(mdu_pkg::MULHSU, 32'hffff_ffff,  32'hffff_ffff, 32'hffff_ffff);
    add_vector(mdu_pkg::MULHSU, 32'd2,          32'h8000_0000, 32'h0000_0001);
    add_vector(mdu_pkg::MULHU,  32'hffff_ffff,  32'hffff_ffff, 32'hffff_fffe);
    add_vector(mdu_pkg::MULHU,  32'h8000_0000,  32'd4,         32'h0000_0002);
    add_vector(mdu_pkg::DIV,    32'hffff_ffec,  32'd3,         32'hffff_fffa);  // -20 / 3
    add_vector(mdu_pkg::DIV,    32'd20,         32'hffff_fffd, 32'hffff_fffa);
    add_vector(mdu_pkg::DIV,    32'hffff_ffec,  32'hffff_fffd, 32'd6);
    add_vector(mdu_pkg::DIVU,   32'hffff_ffec,  32'd3,         32'h5555_554e);
    add_vector(mdu_pkg::REM,    32'hffff_ffec,  32'd3,         32'hffff_fffe);  // Sign of a
    add_vector(mdu_pkg::REM,    32'd20,         32'hffff_fffd, 32'd2);
    add_vector(mdu_pkg::REMU,   32'hffff_ffec,  32'd3,         32'd2);
    add_vector(mdu_pkg::DIV,    32'd5,          32'd0,         32'hffff_ffff);  // Zero divisor
    add_vector(mdu_pkg::DIVU,   32'd5,          32'd0,         32'hffff_ffff);
    add_vector(mdu_pkg::REM,    32'hffff_fffb,  32'd0,         32'hffff_fffb);
    add_vector(mdu_pkg::REMU,   32'h0000_1234,  32'd0,         32'h0000_1234);
    add_vector(mdu_pkg::DIV,    32'h8000_0000,  32'hffff_ffff, 32'h8000_0000);  // Overflow
    add_vector(mdu_pkg::REM,    32'h8000_0000,  32'hffff_ffff, 32'd0);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else begin
      $display("FAILED time %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input string kind, input int errs_before);
    test_num++;
    if (errors == errs_before) begin
      n_pass++;
      $display("test %0d %s: ok", test_num, kind);
    end else begin
      n_fail++;
      $display("test %0d %s: mismatch", test_num, kind);
    end
  endtask

  // One request, then wait for ready and count edges
  task automatic run_op(input mdu_pkg::mdu_op_e op, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] exp, input string kind);
    int edges;
    int errs_before;
    errs_before = errors;
    @(negedge clk);
    while (busy)
      @(negedge clk);
    req.op = op;
    req.a  = a;
    req.b  = b;
    start  = 1'b1;
    @(negedge clk);  // Sampling edge has passed
    start = 1'b0;
    edges = 0;
    while (!ready) begin
      @(negedge clk);
      edges++;
    end
    check_value("result", exp, result);
    check_value("latency", latency, edges);
    report_test(kind, errs_before);
  endtask

  // Second start lands mid-operation and must be dropped
  task automatic busy_start_test();
    int errs_before;
    int pulses;
    int k;
    errs_before = errors;
    @(negedge clk);
    while (busy)
      @(negedge clk);
    req.op = mdu_pkg::DIV;
    req.a  = 32'd100;
    req.b  = 32'd7;
    start  = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (4) @(negedge clk);
    assert (busy)
    else begin
      $display("busy was low while an operation was in flight");
      errors++;
    end
    req.op = mdu_pkg::MUL;  // Must be ignored
    req.a  = 32'd3;
    req.b  = 32'd4;
    start  = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    pulses = 0;
    for (k = 0; k < 50; k++) begin
      @(negedge clk);
      if (ready) begin
        pulses++;
        check_value("result", 32'd14, result);
      end
    end
    check_value("ready pulse count", 32'd1, pulses);
    report_test("start while busy", errs_before);
  endtask

  initial begin
    start       = 1'b0;
    req         = '0;
    seed        = 32'h60df;
    cycle_count = 0;
    fill_table();
    // Busy case counts as two operations
    timeout_limit = (vectors.size() + n_random + 2) * op_cycles + 100;
    wait (reset_n === 1'b1);
    @(negedge clk);
    begin
      int errs_before;
      errs_before = errors;
      check_value("busy", 32'd0, busy);
      check_value("ready", 32'd0, ready);
      check_value("result", 32'd0, result);
      report_test("after reset", errs_before);
    end
    for (i = 0; i < vectors.size(); i++) begin
      cur  = vectors[i];
      op_r = cur.op;
      run_op(op_r, cur.a, cur.b, cur.exp, $sformatf("table %s", op_r.name()));
    end
    busy_start_test();
    for (i = 0; i < n_random; i++) begin
      rnd  = $random(seed);
      op_r = mdu_pkg::mdu_op_e'(rnd[2:0]);
      a_r  = $random(seed);
      b_r  = $random(seed);
      case (rnd[6:4])
        3'd0: b_r = 32'd0;            // Zero divisor
        3'd1: b_r = b_r >> 24;        // Small divisor
        3'd2: begin
          a_r = 32'h8000_0000;        // Overflow corner
          b_r = 32'hffff_ffff;
        end
        default: ;
      endcase
      run_op(op_r, a_r, b_r, model_result(op_r, a_r, b_r),
             $sformatf("random %s", op_r.name()));
    end
    $display("Tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- test/mdu_assert.sv
// Concurrent checks on the start, busy and ready timing of mdu_top
// Bound into mdu_top and sampled on the rising clock edge
// A start only counts when busy is low
`timescale 1ns/100ps

module mdu_assert (
  input logic clk,
  input logic reset_n,
  input logic start,
  input logic busy,
  input logic ready
);

  // Ready rises on the 35th edge after the sampling edge, seen one tick later
  property start_to_ready;
    @(posedge clk) disable iff (!reset_n)
      (start && !busy) |=> ##35 ready;
  endproperty

  property ready_one_cycle;
    @(posedge clk) disable iff (!reset_n)
      ready |=> !ready;
  endproperty

  property ready_inside_busy;
    @(posedge clk) disable iff (!reset_n)
      ready |-> busy;
  endproperty

  // Outputs quiet while reset is held
  property quiet_in_reset;
    @(posedge clk) !reset_n |-> (!ready && !busy);
  endproperty

  latency_a: assert property (start_to_ready)
    else $error("ready missing 35 edges after an accepted start");
  pulse_a: assert property (ready_one_cycle)
    else $error("ready held for more than one cycle");
  busy_a: assert property (ready_inside_busy)
    else $error("ready high while busy low");
  reset_a: assert property (quiet_in_reset)
    else $error("ready or busy high during reset");

endmodule

//--- test/mdu_clock_gen.sv
// Clock and reset for the multiply/divide testbench
// 4 ns period; reset_n low for the first 8 rising edges, released on a falling edge
`timescale 1ns/100ps

module mdu_clock_gen (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // Half period
  end

  initial begin
    reset_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);  // Release away from the active edge
    reset_n = 1'b1;
  end

endmodule

//--- rtl/mdu_top.sv
// RV32 M-extension multiply/divide unit
// start is ignored while busy; ready pulses 35 cycles after an accepted start
// One operation in flight at a time
`timescale 1ns/100ps

module mdu_top (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     start,
  input  mdu_pkg::mdu_req_t        req,
  output logic [mdu_pkg::xlen-1:0] result,
  output logic                     busy,
  output logic                     ready
);

  mdu_pkg::mdu_prep_t prep;
  mdu_pkg::mdu_raw_t  div_raw;
  mdu_pkg::mdu_raw_t  mul_raw;
  mdu_pkg::mdu_raw_t  raw;
  logic               accept;
  logic               go;
  logic               is_div;
  logic               div_done;
  logic               mul_done;

  mdu_operand_prep u_prep (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .req     (req),
    .ready   (ready),
    .accept  (accept),
    .prep    (prep),
    .go      (go)
  );

  // Divide class has funct3[2] set
  assign is_div = prep.op inside {mdu_pkg::DIV, mdu_pkg::DIVU, mdu_pkg::REM, mdu_pkg::REMU};

  mdu_divider u_div (
    .clk     (clk),
    .reset_n (reset_n),
    .go      (go & is_div),
    .prep    (prep),
    .raw     (div_raw),
    .done    (div_done)
  );

  mdu_multiplier u_mul (
    .clk     (clk),
    .reset_n (reset_n),
    .go      (go & ~is_div),
    .prep    (prep),
    .raw     (mul_raw),
    .done    (mul_done)
  );

  assign raw = div_done ? div_raw : mul_raw;  // Only one engine finishes

  mdu_result_format u_fmt (
    .clk     (clk),
    .reset_n (reset_n),
    .done    (div_done | mul_done),
    .raw     (raw),
    .result  (result),
    .ready   (ready)
  );

  assign busy = accept;  // Held through the ready cycle

endmodule

//--- rtl/mdu_result_format.sv
// Output side: sign fix-up and result select, registered on done
// ready is a one-cycle pulse; result holds until the next operation
`timescale 1ns/100ps

module mdu_result_format (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     done,
  input  mdu_pkg::mdu_raw_t        raw,
  output logic [mdu_pkg::xlen-1:0] result,
  output logic                     ready
);

  logic [mdu_pkg::xlen-1:0] res_d;

  always_comb begin
    logic [2*mdu_pkg::xlen-1:0] prod;
    logic [mdu_pkg::xlen-1:0]   quot;
    logic [mdu_pkg::xlen-1:0]   rem;
    prod = {raw.hi, raw.lo};
    if (raw.neg_lo)
      prod = -prod;  // Full 64-bit negate
    quot = raw.neg_lo ? -raw.lo : raw.lo;
    rem  = raw.neg_hi ? -raw.hi : raw.hi;
    case (raw.op)
      mdu_pkg::MUL:    res_d = prod[mdu_pkg::xlen-1:0];
      mdu_pkg::MULH,
      mdu_pkg::MULHSU,
      mdu_pkg::MULHU:  res_d = prod[2*mdu_pkg::xlen-1:mdu_pkg::xlen];  // High half
      mdu_pkg::DIV,
      mdu_pkg::DIVU:   res_d = quot;
      mdu_pkg::REM,
      mdu_pkg::REMU:   res_d = rem;
      default:         res_d = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result <= '0;
      ready  <= 1'b0;
    end else begin
      ready <= done;  // One cycle, since done is one cycle
      if (done)
        result <= res_d;
    end
  end

endmodule

//--- rtl/mdu_multiplier.sv
// Shift-add multiplier over unsigned magnitudes, 64-bit product
// Loads on go, 32 step cycles then one DONE cycle, same latency as the divider
`timescale 1ns/100ps

module mdu_multiplier (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               go,
  input  mdu_pkg::mdu_prep_t prep,
  output mdu_pkg::mdu_raw_t  raw,
  output logic               done
);

  mdu_pkg::eng_state_e          state;
  logic [4:0]                   step;      // Step counter, 0..31
  logic [2*mdu_pkg::xlen-1:0]   acc;       // Upper half sum, lower half multiplier bits
  logic [mdu_pkg::xlen-1:0]     mcand;
  logic [mdu_pkg::xlen:0]       sum;       // Upper half plus carry
  mdu_pkg::mdu_op_e             op_q;
  logic                         neg_lo_q;
  logic                         neg_hi_q;

  // Add multiplicand when the current multiplier bit is set
  assign sum = {1'b0, acc[2*mdu_pkg::xlen-1:mdu_pkg::xlen]}
             + {1'b0, (acc[0] ? mcand : {mdu_pkg::xlen{1'b0}})};

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= mdu_pkg::IDLE;
      step  <= '0;
    end else begin
      case (state)
        mdu_pkg::IDLE: begin
          if (go) begin
            state <= mdu_pkg::RUN;
            step  <= '0;
          end
        end
        mdu_pkg::RUN: begin
          step <= step + 5'd1;
          if (step == 5'd31)
            state <= mdu_pkg::DONE;
        end
        mdu_pkg::DONE: state <= mdu_pkg::IDLE;
        default:       state <= mdu_pkg::IDLE;
      endcase
    end
  end

  // Accumulator shifts right every step, carry enters at the top
  always_ff @(posedge clk) begin
    if (state == mdu_pkg::IDLE && go) begin
      acc      <= {{mdu_pkg::xlen{1'b0}}, prep.mag_b};
      mcand    <= prep.mag_a;
      op_q     <= prep.op;
      neg_lo_q <= prep.neg_lo;
      neg_hi_q <= prep.neg_hi;
    end else if (state == mdu_pkg::RUN) begin
      acc <= {sum, acc[mdu_pkg::xlen-1:1]};
    end
  end

  assign done = (state == mdu_pkg::DONE);

  assign raw.op     = op_q;
  assign raw.lo     = acc[mdu_pkg::xlen-1:0];
  assign raw.hi     = acc[2*mdu_pkg::xlen-1:mdu_pkg::xlen];
  assign raw.neg_lo = neg_lo_q;
  assign raw.neg_hi = neg_hi_q;

endmodule

//--- rtl/mdu_divider.sv
// Restoring divider over unsigned magnitudes, one quotient bit per cycle
// Loads on go, runs 32 steps, then one DONE cycle with done high
// Zero divisor yields all-ones quotient and remainder equal to the dividend
`timescale 1ns/100ps

module mdu_divider (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               go,
  input  mdu_pkg::mdu_prep_t prep,
  output mdu_pkg::mdu_raw_t  raw,
  output logic               done
);

  mdu_pkg::eng_state_e              state;
  logic [mdu_pkg::xlen-1:0]         q_mask;   // Current quotient bit
  logic [mdu_pkg::xlen-1:0]         rem;      // Partial remainder
  logic [2*mdu_pkg::xlen-2:0]       div_sh;   // Divisor shifted up by 31
  logic [mdu_pkg::xlen-1:0]         quot;
  mdu_pkg::mdu_op_e                 op_q;
  logic                             neg_lo_q;
  logic                             neg_hi_q;
  logic                             fits;

  // Divisor fits under the partial remainder
  assign fits = (div_sh <= {{(mdu_pkg::xlen-1){1'b0}}, rem});

  // FSM and step mask
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state  <= mdu_pkg::IDLE;
      q_mask <= '0;
    end else begin
      case (state)
        mdu_pkg::IDLE: begin
          if (go) begin
            state  <= mdu_pkg::RUN;
            q_mask <= {1'b1, {(mdu_pkg::xlen-1){1'b0}}};  // Start at MSB
          end
        end
        mdu_pkg::RUN: begin
          q_mask <= q_mask >> 1;
          if (q_mask[0])
            state <= mdu_pkg::DONE;  // Last bit resolved
        end
        mdu_pkg::DONE: state <= mdu_pkg::IDLE;
        default:       state <= mdu_pkg::IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == mdu_pkg::IDLE && go) begin
      rem      <= prep.mag_a;
      div_sh   <= {prep.mag_b, {(mdu_pkg::xlen-1){1'b0}}};
      quot     <= '0;
      op_q     <= prep.op;
      neg_lo_q <= prep.neg_lo;
      neg_hi_q <= prep.neg_hi;
    end else if (state == mdu_pkg::RUN) begin
      if (fits) begin
        rem  <= rem - div_sh[mdu_pkg::xlen-1:0];  // Upper bits are zero here
        quot <= quot | q_mask;
      end
      div_sh <= div_sh >> 1;
    end
  end

  assign done = (state == mdu_pkg::DONE);

  // Flags pass straight through
  assign raw.op     = op_q;
  assign raw.lo     = quot;
  assign raw.hi     = rem;
  assign raw.neg_lo = neg_lo_q;
  assign raw.neg_hi = neg_hi_q;

endmodule

//--- rtl/mdu_operand_prep.sv
// Input side: captures a request on start and converts operands to magnitudes
// A start is only taken while accept is low; accept drops after ready
// go pulses one cycle after the capture edge
`timescale 1ns/100ps

module mdu_operand_prep (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               start,
  input  mdu_pkg::mdu_req_t  req,
  input  logic               ready,   // Result left the output side
  output logic               accept,  // Holding an operation
  output mdu_pkg::mdu_prep_t prep,
  output logic               go
);

  mdu_pkg::mdu_req_t  req_q;  // Captured request
  mdu_pkg::mdu_prep_t prep_d;
  logic               cap;    // Request captured last edge

  // Signedness decode and magnitudes from the captured request
  always_comb begin
    logic a_signed;
    logic b_signed;
    logic a_neg;
    logic b_neg;
    a_signed = req_q.op inside {mdu_pkg::MUL, mdu_pkg::MULH, mdu_pkg::MULHSU,
                                mdu_pkg::DIV, mdu_pkg::REM};
    b_signed = req_q.op inside {mdu_pkg::MUL, mdu_pkg::MULH, mdu_pkg::DIV, mdu_pkg::REM};
    a_neg = a_signed & req_q.a[mdu_pkg::xlen-1];
    b_neg = b_signed & req_q.b[mdu_pkg::xlen-1];
    prep_d.op    = req_q.op;
    prep_d.mag_a = a_neg ? -req_q.a : req_q.a;
    prep_d.mag_b = b_neg ? -req_q.b : req_q.b;
    if (req_q.op inside {mdu_pkg::MUL, mdu_pkg::MULH, mdu_pkg::MULHSU, mdu_pkg::MULHU}) begin
      prep_d.neg_lo = a_neg ^ b_neg;  // Negate whole product
      prep_d.neg_hi = 1'b0;
    end else begin
      prep_d.neg_lo = (a_neg ^ b_neg) & (|req_q.b);  // Zero divisor keeps all ones
      prep_d.neg_hi = a_neg;                         // Remainder follows dividend
    end
  end

  // Control
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      accept <= 1'b0;
      cap    <= 1'b0;
      go     <= 1'b0;
    end else begin
      cap <= start & ~accept;
      go  <= cap;
      if (start && !accept)
        accept <= 1'b1;
      else if (ready)
        accept <= 1'b0;  // Operation finished
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (start && !accept)
      req_q <= req;
    if (cap)
      prep <= prep_d;
  end

endmodule

//--- rtl/mdu_pkg.sv
// Shared types for the RV32 M-extension multiply/divide unit
// Operand width is fixed at one 32-bit word; no RV64 or W-suffix ops
// Opcode encoding follows funct3 of the M extension

package mdu_pkg;

  localparam int xlen = 32;  // One RV32 word

  // M-extension opcodes, funct3 order
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } mdu_op_e;

  // Iterative engine states, shared by divider and multiplier
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } eng_state_e;

  // Incoming request, 67 bits
  typedef struct packed {
    mdu_op_e          op;
    logic [xlen-1:0]  a;  // rs1
    logic [xlen-1:0]  b;  // rs2
  } mdu_req_t;

  // Operands as magnitudes plus negate flags, 69 bits
  typedef struct packed {
    mdu_op_e          op;
    logic [xlen-1:0]  mag_a;
    logic [xlen-1:0]  mag_b;
    logic             neg_lo;  // Product, or quotient for divides
    logic             neg_hi;  // Remainder for divides
  } mdu_prep_t;

  // Unsigned engine result, 69 bits
  typedef struct packed {
    mdu_op_e          op;
    logic [xlen-1:0]  lo;      // Product low half or quotient
    logic [xlen-1:0]  hi;      // Product high half or remainder
    logic             neg_lo;
    logic             neg_hi;
  } mdu_raw_t;

endpackage
